// File: hw/cmd_decoder.sv
`timescale 1ns/1ps

module cmd_decoder import dbg_pkg::*; (
    input  logic  clk,
    input  logic  rst,

    input  cmd_t  cmd,
    input  logic  cmd_valid,
    output logic  cmd_ready,
    output logic  cmd_done,

    output ctrl_t rd_ctrl,
    output ctrl_t wr_ctrl,

    output data_t rd_inj_data,
    output logic  rd_inj_valid,
    input  logic  rd_inj_ready,

    output data_t wr_inj_data,
    output logic  wr_inj_valid,
    input  logic  wr_inj_ready
);

    typedef enum logic [1:0] {
        st_idle,
        st_inject_wait,
        st_done
    } state_e;

    state_e state;
    ctrl_t  rd_ctrl_q;
    ctrl_t  wr_ctrl_q;
    data_t  inj_data_q;
    chan_e  inj_chan_q;
    logic   cmd_fire;
    logic   inj_fire;

    // set or clear one flag of a channel record
    function automatic ctrl_t apply_op(input ctrl_t c, input opcode_e op);
        ctrl_t r;
        r = c;
        case (op)
            op_pause:   r.pause  = 1'b1;
            op_unpause: r.pause  = 1'b0;
            op_drop:    r.drop   = 1'b1;
            op_undrop:  r.drop   = 1'b0;
            op_log:     r.log_en = 1'b1;
            op_unlog:   r.log_en = 1'b0;
            default:    r = c;
        endcase
        return r;
    endfunction

    //////////////////////////////////////////////////
    // handshakes
    //////////////////////////////////////////////////

    // done state still takes the next command
    assign cmd_ready = (state != st_inject_wait);
    assign cmd_fire  = cmd_valid && cmd_ready;
    assign cmd_done  = (state == st_done);

    assign rd_inj_valid = (state == st_inject_wait) && (inj_chan_q == chan_rd);
    assign wr_inj_valid = (state == st_inject_wait) && (inj_chan_q == chan_wr);
    assign rd_inj_data  = inj_data_q;
    assign wr_inj_data  = inj_data_q;

    assign inj_fire = (rd_inj_valid && rd_inj_ready) || (wr_inj_valid && wr_inj_ready);

    assign rd_ctrl = rd_ctrl_q;
    assign wr_ctrl = wr_ctrl_q;

    //////////////////////////////////////////////////
    // command FSM
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= st_idle;
            rd_ctrl_q <= '0;
            wr_ctrl_q <= '0;
        end else begin
            case (state)
                st_inject_wait: begin
                    if (inj_fire) begin
                        state <= st_done;
                    end
                end
                default: begin
                    if (cmd_fire && cmd.opcode == op_inject) begin
                        state <= st_inject_wait;
                    end else if (cmd_fire) begin
                        state <= st_done;
                        if (cmd.chan == chan_rd) begin
                            rd_ctrl_q <= apply_op(rd_ctrl_q, cmd.opcode);
                        end else begin
                            wr_ctrl_q <= apply_op(wr_ctrl_q, cmd.opcode);
                        end
                    end else begin
                        state <= st_idle;
                    end
                end
            endcase
        end
    end

    // inject beat, payload zero extended
    always_ff @(posedge clk) begin
        if (cmd_fire && cmd.opcode == op_inject) begin
            inj_data_q <= {{(data_w - payload_w){1'b0}}, cmd.payload};
            inj_chan_q <= cmd.chan;
        end
    end

    // only one governor is offered an inject at a time
    a_one_inject: assert property (
        @(posedge clk) disable iff (rst)
        !(rd_inj_valid && wr_inj_valid)
    ) else $error("inject offered on both channels");

endmodule

// File: hw/dbg_datapath.sv
`timescale 1ns/1ps

module dbg_datapath import dbg_pkg::*; (
    input  logic      clk,
    input  logic      rst,

    // read channel, device to host
    input  data_t     rd_in_data,
    input  logic      rd_in_valid,
    output logic      rd_in_ready,
    output data_t     rd_out_data,
    output logic      rd_out_valid,
    input  logic      rd_out_ready,

    // write channel, host to device
    input  data_t     wr_in_data,
    input  logic      wr_in_valid,
    output logic      wr_in_ready,
    output data_t     wr_out_data,
    output logic      wr_out_valid,
    input  logic      wr_out_ready,

    input  cmd_t      cmd,
    input  logic      cmd_valid,
    output logic      cmd_ready,
    output logic      cmd_done,

    output log_beat_t log,
    output logic      log_valid,
    input  logic      log_ready
);

    ctrl_t rd_ctrl;
    ctrl_t wr_ctrl;

    data_t rd_inj_data;
    logic  rd_inj_valid;
    logic  rd_inj_ready;
    data_t wr_inj_data;
    logic  wr_inj_valid;
    logic  wr_inj_ready;

    data_t rd_log_data;
    logic  rd_log_valid;
    logic  rd_log_ready;
    data_t wr_log_data;
    logic  wr_log_valid;
    logic  wr_log_ready;

    //////////////////////////////////////////////////
    // command side
    //////////////////////////////////////////////////

    cmd_decoder u_decoder (
        .clk          (clk),
        .rst          (rst),
        .cmd          (cmd),
        .cmd_valid    (cmd_valid),
        .cmd_ready    (cmd_ready),
        .cmd_done     (cmd_done),
        .rd_ctrl      (rd_ctrl),
        .wr_ctrl      (wr_ctrl),
        .rd_inj_data  (rd_inj_data),
        .rd_inj_valid (rd_inj_valid),
        .rd_inj_ready (rd_inj_ready),
        .wr_inj_data  (wr_inj_data),
        .wr_inj_valid (wr_inj_valid),
        .wr_inj_ready (wr_inj_ready)
    );

    //////////////////////////////////////////////////
    // governors
    //////////////////////////////////////////////////

    stream_governor u_gov_rd (
        .clk       (clk),
        .rst       (rst),
        .ctrl      (rd_ctrl),
        .in_data   (rd_in_data),
        .in_valid  (rd_in_valid),
        .in_ready  (rd_in_ready),
        .inj_data  (rd_inj_data),
        .inj_valid (rd_inj_valid),
        .inj_ready (rd_inj_ready),
        .out_data  (rd_out_data),
        .out_valid (rd_out_valid),
        .out_ready (rd_out_ready),
        .log_data  (rd_log_data),
        .log_valid (rd_log_valid),
        .log_ready (rd_log_ready)
    );

    stream_governor u_gov_wr (
        .clk       (clk),
        .rst       (rst),
        .ctrl      (wr_ctrl),
        .in_data   (wr_in_data),
        .in_valid  (wr_in_valid),
        .in_ready  (wr_in_ready),
        .inj_data  (wr_inj_data),
        .inj_valid (wr_inj_valid),
        .inj_ready (wr_inj_ready),
        .out_data  (wr_out_data),
        .out_valid (wr_out_valid),
        .out_ready (wr_out_ready),
        .log_data  (wr_log_data),
        .log_valid (wr_log_valid),
        .log_ready (wr_log_ready)
    );

    // shared log output
    log_merge u_log (
        .clk       (clk),
        .rst       (rst),
        .rd_data   (rd_log_data),
        .rd_valid  (rd_log_valid),
        .rd_ready  (rd_log_ready),
        .wr_data   (wr_log_data),
        .wr_valid  (wr_log_valid),
        .wr_ready  (wr_log_ready),
        .log       (log),
        .log_valid (log_valid),
        .log_ready (log_ready)
    );

endmodule

// File: hw/dbg_pkg.sv
package dbg_pkg;

    //////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////

    localparam int data_w    = 32;
    localparam int payload_w = 16;

    typedef logic [data_w-1:0] data_t;

    //////////////////////////////////////////////////
    // command encoding
    //////////////////////////////////////////////////

    // channel select, rd runs device to host
    typedef enum logic {
        chan_rd = 1'b0,
        chan_wr = 1'b1
    } chan_e;

    typedef enum logic [3:0] {
        op_nop     = 4'd0,
        op_pause   = 4'd1,
        op_unpause = 4'd2,
        op_drop    = 4'd3,
        op_undrop  = 4'd4,
        op_inject  = 4'd5,
        op_log     = 4'd6,
        op_unlog   = 4'd7
    } opcode_e;

    typedef struct packed {
        opcode_e                opcode;
        chan_e                  chan;
        logic [payload_w-1:0]   payload;
    } cmd_t;

    // per-channel control flags
    typedef struct packed {
        logic pause;
        logic drop;
        logic log_en;
    } ctrl_t;

    typedef struct packed {
        chan_e chan;
        data_t data;
    } log_beat_t;

endpackage

// File: hw/log_merge.sv
`timescale 1ns/1ps

module log_merge import dbg_pkg::*; (
    input  logic      clk,
    input  logic      rst,

    input  data_t     rd_data,
    input  logic      rd_valid,
    output logic      rd_ready,

    input  data_t     wr_data,
    input  logic      wr_valid,
    output logic      wr_ready,

    output log_beat_t log,
    output logic      log_valid,
    input  logic      log_ready
);

    chan_e last_grant;
    logic  out_free;
    logic  pick_wr;

    assign out_free = !log_valid || log_ready;

    // round robin when both pending
    assign pick_wr  = wr_valid && (!rd_valid || last_grant == chan_rd);
    assign rd_ready = out_free && rd_valid && !pick_wr;
    assign wr_ready = out_free && pick_wr;

    always_ff @(posedge clk) begin
        if (rst) begin
            log_valid  <= 1'b0;
            last_grant <= chan_wr;
        end else if (rd_ready || wr_ready) begin
            log_valid  <= 1'b1;
            last_grant <= pick_wr ? chan_wr : chan_rd;
        end else if (log_ready) begin
            log_valid  <= 1'b0;
        end
    end

    // tag with source channel
    always_ff @(posedge clk) begin
        if (rd_ready || wr_ready) begin
            log.chan <= pick_wr ? chan_wr : chan_rd;
            log.data <= pick_wr ? wr_data : rd_data;
        end
    end

    a_one_grant: assert property (
        @(posedge clk) disable iff (rst)
        !(rd_ready && wr_ready)
    ) else $error("log merge granted both channels");

endmodule

// File: hw/stream_governor.sv
`timescale 1ns/1ps

module stream_governor import dbg_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  ctrl_t ctrl,

    input  data_t in_data,
    input  logic  in_valid,
    output logic  in_ready,

    input  data_t inj_data,
    input  logic  inj_valid,
    output logic  inj_ready,

    output data_t out_data,
    output logic  out_valid,
    input  logic  out_ready,

    output data_t log_data,
    output logic  log_valid,
    input  logic  log_ready
);

    logic  out_free;
    logic  log_free;
    logic  load_ok;
    logic  inj_fire;
    logic  in_fire;
    logic  load;
    data_t load_data;

    //////////////////////////////////////////////////
    // acceptance
    //////////////////////////////////////////////////

    // register is free or drains this cycle
    assign out_free = !out_valid || out_ready;
    assign log_free = !log_valid || log_ready;

    // log space only matters while logging
    assign load_ok = out_free && (!ctrl.log_en || log_free);

    // inject ignores pause and drop
    assign inj_ready = load_ok;
    assign inj_fire  = inj_valid && inj_ready;

    // dropped beats need no space, inject wins otherwise
    assign in_ready = !ctrl.pause && (ctrl.drop || (load_ok && !inj_valid));
    assign in_fire  = in_valid && in_ready;

    assign load      = inj_fire || (in_fire && !ctrl.drop);
    assign load_data = inj_fire ? inj_data : in_data;

    //////////////////////////////////////////////////
    // output and log registers
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            log_valid <= 1'b0;
        end else begin
            if (load) begin
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end

            // copy taken in the same cycle as the output load
            if (load && ctrl.log_en) begin
                log_valid <= 1'b1;
            end else if (log_ready) begin
                log_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            out_data <= load_data;
        end
        if (load && ctrl.log_en) begin
            log_data <= load_data;
        end
    end

    // stalled output beat must not change
    a_out_stable: assert property (
        @(posedge clk) disable iff (rst)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data))
    ) else $error("out beat changed while stalled");

endmodule

// File: project.f
hw/dbg_pkg.sv
hw/stream_governor.sv
hw/cmd_decoder.sv
hw/log_merge.sv
hw/dbg_datapath.sv
sim/tb_clock_gen.sv
sim/tb_dbg_datapath.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it and look for the pass line in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module tb_dbg_datapath -o tb_sim \
    > build.log 2>&1 \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    || { echo "build or run failed, see build.log and sim.log"; exit 1; }

grep -qx "sim passed" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }

// File: sim/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // high over the first 5 rising edges, released on a falling edge
    initial begin
        rst = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

// File: sim/tb_dbg_datapath.sv
`timescale 1ns/1ps

module tb_dbg_datapath import dbg_pkg::*; ();

    // one row of the stimulus table
    typedef struct {
        bit                   has_cmd;
        opcode_e              op;
        chan_e                ch;
        logic [payload_w-1:0] payload;
        int                   n_rd;
        int                   n_wr;
        int                   exp_rd;
        int                   exp_wr;
        int                   exp_log;
        bit                   bp;
    } step_t;

    logic      clk;
    logic      rst;
    logic      in_valid [2];
    data_t     in_data [2];
    logic      in_ready [2];
    data_t     out_data [2];
    logic      out_valid [2];
    logic      out_ready [2];
    cmd_t      cmd;
    logic      cmd_valid;
    logic      cmd_ready;
    logic      cmd_done;
    log_beat_t log;
    logic      log_valid;
    logic      log_ready;

    // index 0 is rd and 1 is wr
    logic [31:0] rng;
    bit          bp;
    int          target [2];
    int          sent [2];
    int          acc [2];
    int          got [2];
    int          got_log;
    int          done_cnt;
    int          cmd_acc;
    int          mon_errors;
    int          fails;
    bit          timed_out;
    bit          pause_f [2];
    bit          drop_f [2];
    bit          log_f [2];
    data_t       out_q_rd [$];
    data_t       out_q_wr [$];
    data_t       log_q_rd [$];
    data_t       log_q_wr [$];
    step_t       steps [$];

    tb_clock_gen u_clk (
        .clk (clk),
        .rst (rst)
    );

    dbg_datapath u_dut (
        .clk          (clk),
        .rst          (rst),
        .rd_in_data   (in_data[0]),
        .rd_in_valid  (in_valid[0]),
        .rd_in_ready  (in_ready[0]),
        .rd_out_data  (out_data[0]),
        .rd_out_valid (out_valid[0]),
        .rd_out_ready (out_ready[0]),
        .wr_in_data   (in_data[1]),
        .wr_in_valid  (in_valid[1]),
        .wr_in_ready  (in_ready[1]),
        .wr_out_data  (out_data[1]),
        .wr_out_valid (out_valid[1]),
        .wr_out_ready (out_ready[1]),
        .cmd          (cmd),
        .cmd_valid    (cmd_valid),
        .cmd_ready    (cmd_ready),
        .cmd_done     (cmd_done),
        .log          (log),
        .log_valid    (log_valid),
        .log_ready    (log_ready)
    );

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic add_step(input bit has_cmd, input opcode_e op, input chan_e ch,
                            input logic [15:0] payload, input int n_rd, input int n_wr,
                            input int exp_rd, input int exp_wr, input int exp_log,
                            input bit bp_on);
        step_t s;
        s = '{has_cmd, op, ch, payload, n_rd, n_wr, exp_rd, exp_wr, exp_log, bp_on};
        steps.push_back(s);
    endtask

    task automatic report_error(input string msg);
        $display("ERROR %0d ns: %s", $time, msg);
        mon_errors++;
    endtask

    // expected beat on the output and also on the log when logged
    task automatic expect_beat(input int c, input data_t d);
        if (c == 0) begin
            out_q_rd.push_back(d);
            if (log_f[0]) log_q_rd.push_back(d);
        end else begin
            out_q_wr.push_back(d);
            if (log_f[1]) log_q_wr.push_back(d);
        end
    endtask

    task automatic check_beat(input bit on_log, input int c, input data_t d);
        data_t exp;
        int    n;
        n = on_log ? (c == 0 ? log_q_rd.size() : log_q_wr.size())
                   : (c == 0 ? out_q_rd.size() : out_q_wr.size());
        if (n == 0) begin
            report_error($sformatf("unexpected %s beat %h from channel %0d",
                                   on_log ? "log" : "output", d, c));
            return;
        end
        if (on_log && c == 0) exp = log_q_rd.pop_front();
        else if (on_log) exp = log_q_wr.pop_front();
        else if (c == 0) exp = out_q_rd.pop_front();
        else exp = out_q_wr.pop_front();
        if (d !== exp) begin
            report_error($sformatf("%s beat of channel %0d is %h, expected %h",
                                   on_log ? "log" : "output", c, d, exp));
        end
    endtask

    // flag model per opcode and the injected beat
    task automatic apply_cmd(input cmd_t c_in);
        int ch;
        ch = int'(c_in.chan);
        case (c_in.opcode)
            op_pause:   pause_f[ch] = 1'b1;
            op_unpause: pause_f[ch] = 1'b0;
            op_drop:    drop_f[ch]  = 1'b1;
            op_undrop:  drop_f[ch]  = 1'b0;
            op_log:     log_f[ch]   = 1'b1;
            op_unlog:   log_f[ch]   = 1'b0;
            op_inject:  expect_beat(ch, data_t'(c_in.payload));
            default:    ;
        endcase
    endtask

    task automatic send_command(input step_t s, input int idx, input int b_done);
        int base;
        int n;
        base = cmd_acc;
        cmd.opcode = s.op;
        cmd.chan = s.ch;
        cmd.payload = s.payload;
        cmd_valid = 1'b1;
        n = 0;
        while (cmd_acc == base && n < 200) begin
            @(negedge clk);
            n++;
        end
        cmd_valid = 1'b0;
        n = 0;
        while (cmd_acc != base && done_cnt == b_done && n < 500) begin
            @(negedge clk);
            n++;
        end
        if (cmd_acc == base || done_cnt == b_done) begin
            $display("step %0d: command never accepted or never completed", idx);
            timed_out = 1'b1;
        end
    endtask

    function automatic bit step_reached(input step_t s, input int b_rd, input int b_wr,
                                        input int b_log);
        return (got[0] - b_rd >= s.exp_rd) && (got[1] - b_wr >= s.exp_wr)
            && (got_log - b_log >= s.exp_log)
            && (acc[0] >= target[0] || pause_f[0]) && (acc[1] >= target[1] || pause_f[1]);
    endfunction

    //////////////////////////////////////////////////
    // drivers on the falling edge
    //////////////////////////////////////////////////

    initial begin
        rng = 32'hcc3402d3;
        for (int c = 0; c < 2; c++) begin
            in_valid[c] = 1'b0;
            in_data[c] = '0;
            out_ready[c] = 1'b1;
            sent[c] = 0;
        end
        log_ready = 1'b1;
        forever begin
            @(negedge clk);
            for (int c = 0; c < 2; c++) begin
                // beat taken at the last rising edge
                if (in_valid[c] && acc[c] == sent[c]) in_valid[c] = 1'b0;
                if (!in_valid[c] && sent[c] < target[c]) begin
                    rng = xorshift32(rng);
                    in_data[c] = rng;
                    in_valid[c] = 1'b1;
                    sent[c]++;
                end
            end
            rng = xorshift32(rng);
            out_ready[0] = bp ? rng[3] : 1'b1;
            out_ready[1] = bp ? rng[11] : 1'b1;
            log_ready = bp ? rng[19] : 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // monitor and scoreboard on the rising edge
    //////////////////////////////////////////////////

    initial begin
        for (int c = 0; c < 2; c++) begin
            acc[c] = 0;
            got[c] = 0;
            pause_f[c] = 1'b0;
            drop_f[c] = 1'b0;
            log_f[c] = 1'b0;
        end
        got_log = 0;
        done_cnt = 0;
        cmd_acc = 0;
        mon_errors = 0;
        forever begin
            @(posedge clk);
            if (!rst) begin
                for (int c = 0; c < 2; c++) begin
                    if (in_valid[c] && in_ready[c]) begin
                        acc[c]++;
                        if (!drop_f[c]) expect_beat(c, in_data[c]);
                    end
                    if (drop_f[c] && !pause_f[c] && !in_ready[c]) begin
                        report_error($sformatf("in_ready low on dropping channel %0d", c));
                    end
                    if (out_valid[c] && out_ready[c]) begin
                        got[c]++;
                        check_beat(1'b0, c, out_data[c]);
                    end
                end
                if (log_valid && log_ready) begin
                    got_log++;
                    check_beat(1'b1, int'(log.chan), log.data);
                end
                if (cmd_done) done_cnt++;
                // flags move after the beats of this edge
                if (cmd_valid && cmd_ready) begin
                    cmd_acc++;
                    apply_cmd(cmd);
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // step table and main sequence
    //////////////////////////////////////////////////

    initial begin
        step_t s;
        string op_name;
        int    n;
        int    b_rd;
        int    b_wr;
        int    b_log;
        int    b_done;
        int    b_err;
        int    run;
        int    bad_steps;
        bit    counts_ok;
        cmd = '0;
        cmd_valid = 1'b0;
        bp = 1'b0;
        target[0] = 0;
        target[1] = 0;
        fails = 0;
        timed_out = 1'b0;
        run = 0;
        bad_steps = 0;

        //       cmd   opcode      chan     payload   send    expect rd wr log  bp
        add_step(1'b1, op_nop,     chan_rd, 16'h0000, 6,  6,  6,  6,  0,  1'b0);
        add_step(1'b0, op_nop,     chan_rd, 16'h0000, 12, 12, 12, 12, 0,  1'b1);
        add_step(1'b1, op_pause,   chan_rd, 16'h0000, 3,  3,  0,  3,  0,  1'b0);
        add_step(1'b1, op_unpause, chan_rd, 16'h0000, 0,  0,  3,  0,  0,  1'b0);
        add_step(1'b1, op_pause,   chan_wr, 16'h0000, 2,  4,  2,  0,  0,  1'b0);
        add_step(1'b1, op_unpause, chan_wr, 16'h0000, 0,  0,  0,  4,  0,  1'b0);
        add_step(1'b1, op_drop,    chan_rd, 16'h0000, 4,  2,  0,  2,  0,  1'b0);
        add_step(1'b1, op_undrop,  chan_rd, 16'h0000, 3,  3,  3,  3,  0,  1'b0);
        add_step(1'b1, op_inject,  chan_rd, 16'hbeef, 0,  0,  1,  0,  0,  1'b0);
        add_step(1'b1, op_log,     chan_rd, 16'h0000, 4,  4,  4,  4,  4,  1'b0);
        add_step(1'b1, op_log,     chan_wr, 16'h0000, 5,  5,  5,  5,  10, 1'b1);
        add_step(1'b1, op_unlog,   chan_rd, 16'h0000, 2,  2,  2,  2,  2,  1'b0);
        add_step(1'b1, op_inject,  chan_wr, 16'h1234, 0,  0,  0,  1,  1,  1'b0);
        add_step(1'b1, op_unlog,   chan_wr, 16'h0000, 3,  3,  3,  3,  0,  1'b0);

        n = 0;
        while (rst !== 1'b0 && n < 100) begin
            @(negedge clk);
            n++;
        end
        if (rst !== 1'b0) begin
            $display("reset was never released");
            timed_out = 1'b1;
        end

        for (int i = 0; i < steps.size() && !timed_out; i++) begin
            s = steps[i];
            op_name = s.has_cmd ? s.op.name() : "none";
            @(negedge clk);
            b_rd = got[0];
            b_wr = got[1];
            b_log = got_log;
            b_done = done_cnt;
            b_err = mon_errors + fails;
            if (s.has_cmd) send_command(s, i, b_done);
            if (!timed_out) begin
                @(posedge clk);
                bp = s.bp;
                target[0] += s.n_rd;
                target[1] += s.n_wr;
                n = 0;
                while (!step_reached(s, b_rd, b_wr, b_log) && n < 2000) begin
                    @(negedge clk);
                    n++;
                end
                if (!step_reached(s, b_rd, b_wr, b_log)) begin
                    $display("step %0d: beats did not arrive before the timeout", i);
                    timed_out = 1'b1;
                end
            end
            if (!timed_out) begin
                // extra beats in the quiet window show up in the counts
                repeat (10) @(negedge clk);
                run++;
                counts_ok = (got[0] - b_rd == s.exp_rd) && (got[1] - b_wr == s.exp_wr)
                         && (got_log - b_log == s.exp_log)
                         && (done_cnt - b_done == (s.has_cmd ? 1 : 0));
                if (!counts_ok) begin
                    $display("ERROR %0d ns: step %0d counts rd %0d wr %0d log %0d done %0d",
                             $time, i, got[0] - b_rd, got[1] - b_wr, got_log - b_log,
                             done_cnt - b_done);
                    fails++;
                end
                if (mon_errors + fails != b_err) bad_steps++;
                $display("step %0d %s: rd %0d/%0d wr %0d/%0d log %0d/%0d, %s", i, op_name,
                         got[0] - b_rd, s.exp_rd, got[1] - b_wr, s.exp_wr,
                         got_log - b_log, s.exp_log,
                         (mon_errors + fails == b_err) ? "ok" : "failed");
            end
        end

        if (!timed_out && out_q_rd.size() + out_q_wr.size() + log_q_rd.size()
            + log_q_wr.size() != 0) begin
            $display("some expected beats were never delivered");
            fails++;
        end
        $display("%0d of %0d steps run, %0d failed, %0d errors", run, steps.size(),
                 bad_steps, mon_errors + fails);
        if (!timed_out && mon_errors + fails == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
